/* design/lite_addr_pkg.sv */
package lite_addr_pkg;

  localparam int paddr_width_c  = 32;
  localparam int dev_width_c    = 4;
  localparam int offset_width_c = 20;

  // Everything below the DRAM base is local space
  localparam logic [paddr_width_c-1:0] dram_base_c = 32'h8000_0000;

  localparam logic [dev_width_c-1:0] clint_dev_c = 4'd1;
  localparam logic [dev_width_c-1:0] cfg_dev_c   = 4'd2;
  localparam logic [dev_width_c-1:0] host_dev_c  = 4'd3;
  localparam logic [dev_width_c-1:0] boot_dev_c  = 4'd4;
  localparam logic [dev_width_c-1:0] cache_dev_c = 4'd5;

  localparam logic [offset_width_c-1:0] clint_msip_c     = 20'h0_0000;
  localparam logic [offset_width_c-1:0] clint_mtimecmp_c = 20'h0_4000;
  localparam logic [offset_width_c-1:0] clint_mtime_c    = 20'h0_bff8;

  localparam logic [offset_width_c-1:0] cfg_freeze_c  = 20'h0_0000;
  localparam logic [offset_width_c-1:0] cfg_scratch_c = 20'h0_0008;

  typedef struct packed
  {
    logic [7:0]                pad;
    logic [dev_width_c-1:0]    dev;
    logic [offset_width_c-1:0] offset;
  } local_addr_s;

  // Same word seen as a flat address or as a device/offset pair
  typedef union packed
  {
    logic [paddr_width_c-1:0] raw;
    local_addr_s              loc;
  } paddr_u;

endpackage

/* design/lite_mem_pkg.sv */
package lite_mem_pkg;

  localparam int data_width_c   = 64;
  localparam int lce_id_width_c = 2;
  localparam int num_req_c      = 3;

  typedef enum logic [0:0]
  {
    e_uc_rd = 1'b0,
    e_uc_wr = 1'b1
  } mem_op_e;

  typedef struct packed
  {
    mem_op_e                   opcode;
    lite_addr_pkg::paddr_u     addr;
    logic [1:0]                size;
    logic [lce_id_width_c-1:0] lce_id;
  } mem_header_s;

  typedef struct packed
  {
    mem_header_s             header;
    logic [data_width_c-1:0] data;
  } mem_msg_s;

endpackage

/* design/uncore_cmd_router.sv */
`timescale 1ns/1ps

module uncore_cmd_router
  (input                                                         clk_i
   , input                                                       reset_i

   , input lite_mem_pkg::mem_msg_s [lite_mem_pkg::num_req_c-1:0] req_cmd_i
   , input [lite_mem_pkg::num_req_c-1:0]                         req_cmd_v_i
   , output logic [lite_mem_pkg::num_req_c-1:0]                  req_cmd_yumi_o

   , output lite_mem_pkg::mem_msg_s                              cmd_sel_o
   , output logic                                                mem_cmd_v_o
   , output logic                                                io_cmd_v_o
   , output logic                                                clint_cmd_v_o
   , output logic                                                cfg_cmd_v_o
   , output logic                                                loop_cmd_v_o

   , input                                                       mem_cmd_ready_and_i
   , input                                                       io_cmd_ready_and_i
   , input                                                       clint_ready_and_i
   , input                                                       cfg_ready_and_i
   , input                                                       loop_ready_and_i
   );

  logic [lite_mem_pkg::num_req_c-1:0] grant;
  lite_addr_pkg::paddr_u addr;
  logic any_v, is_local, is_mem, is_io, is_clint, is_cfg, is_loop, accepted;

  // Later (higher) index overrides, so requester 2 wins
  always_comb
  begin
    grant = '0;
    cmd_sel_o = req_cmd_i[0];
    for (int i = 0; i < lite_mem_pkg::num_req_c; i++)
    begin
      if (req_cmd_v_i[i])
      begin
        grant = '0;
        grant[i] = 1'b1;
        cmd_sel_o = req_cmd_i[i];
      end
    end
  end

  assign any_v = |req_cmd_v_i;
  assign addr  = cmd_sel_o.header.addr;

  assign is_local = (addr.raw < lite_addr_pkg::dram_base_c);
  assign is_mem   = ~is_local | (addr.loc.dev == lite_addr_pkg::cache_dev_c);
  assign is_io    = is_local & ((addr.loc.dev == lite_addr_pkg::host_dev_c)
                               | (addr.loc.dev == lite_addr_pkg::boot_dev_c));
  assign is_clint = is_local & (addr.loc.dev == lite_addr_pkg::clint_dev_c);
  assign is_cfg   = is_local & (addr.loc.dev == lite_addr_pkg::cfg_dev_c);
  assign is_loop  = ~is_mem & ~is_io & ~is_clint & ~is_cfg;

  assign mem_cmd_v_o   = any_v & is_mem;
  assign io_cmd_v_o    = any_v & is_io;
  assign clint_cmd_v_o = any_v & is_clint;
  assign cfg_cmd_v_o   = any_v & is_cfg;
  assign loop_cmd_v_o  = any_v & is_loop;

  // Only the one selected destination can take the command
  assign accepted = (mem_cmd_v_o & mem_cmd_ready_and_i)
                  | (io_cmd_v_o & io_cmd_ready_and_i)
                  | (clint_cmd_v_o & clint_ready_and_i)
                  | (cfg_cmd_v_o & cfg_ready_and_i)
                  | (loop_cmd_v_o & loop_ready_and_i);

  assign req_cmd_yumi_o = grant & {lite_mem_pkg::num_req_c{accepted}};

endmodule

/* design/uncore_resp_router.sv */
`timescale 1ns/1ps

module uncore_resp_router
  (input                                                          clk_i
   , input                                                        reset_i

   , input lite_mem_pkg::mem_msg_s                                loop_resp_i
   , input                                                        loop_resp_v_i
   , output logic                                                 loop_resp_yumi_o
   , input lite_mem_pkg::mem_msg_s                                mem_resp_i
   , input                                                        mem_resp_v_i
   , output logic                                                 mem_resp_yumi_o
   , input lite_mem_pkg::mem_msg_s                                io_resp_i
   , input                                                        io_resp_v_i
   , output logic                                                 io_resp_yumi_o
   , input lite_mem_pkg::mem_msg_s                                clint_resp_i
   , input                                                        clint_resp_v_i
   , output logic                                                 clint_resp_yumi_o
   , input lite_mem_pkg::mem_msg_s                                cfg_resp_i
   , input                                                        cfg_resp_v_i
   , output logic                                                 cfg_resp_yumi_o

   , output lite_mem_pkg::mem_msg_s [lite_mem_pkg::num_req_c-1:0] req_resp_o
   , output logic [lite_mem_pkg::num_req_c-1:0]                   req_resp_v_o
   , input [lite_mem_pkg::num_req_c-1:0]                          req_resp_ready_and_i
   );

  // Index 0 is the highest priority source
  lite_mem_pkg::mem_msg_s [4:0] resp_li;
  logic [4:0] resp_v_li, grant, yumi_lo;
  lite_mem_pkg::mem_msg_s winner;
  logic any_v, taken;

  assign resp_li   = {cfg_resp_i, clint_resp_i, io_resp_i, mem_resp_i, loop_resp_i};
  assign resp_v_li = {cfg_resp_v_i, clint_resp_v_i, io_resp_v_i, mem_resp_v_i, loop_resp_v_i};

  always_comb
  begin
    grant = '0;
    winner = resp_li[0];
    for (int i = 4; i >= 0; i--)
    begin
      if (resp_v_li[i])
      begin
        grant = '0;
        grant[i] = 1'b1;
        winner = resp_li[i];
      end
    end
  end

  assign any_v = |resp_v_li;

  for (genvar i = 0; i < lite_mem_pkg::num_req_c; i++)
  begin : steer
    assign req_resp_o[i]   = winner;
    assign req_resp_v_o[i] = any_v
      & (winner.header.lce_id == lite_mem_pkg::lce_id_width_c'(i));
  end

  // A response with no matching requester is never taken
  assign taken   = |(req_resp_v_o & req_resp_ready_and_i);
  assign yumi_lo = grant & {5{taken}};

  assign {cfg_resp_yumi_o, clint_resp_yumi_o, io_resp_yumi_o, mem_resp_yumi_o,
          loop_resp_yumi_o} = yumi_lo;

endmodule

/* design/uncore_clint.sv */
`timescale 1ns/1ps

module uncore_clint
  #(parameter int timer_prescale_p = 1)
  (input                            clk_i
   , input                          reset_i

   , input lite_mem_pkg::mem_msg_s  cmd_i
   , input                          cmd_v_i
   , output logic                   cmd_ready_and_o

   , output lite_mem_pkg::mem_msg_s resp_o
   , output logic                   resp_v_o
   , input                          resp_yumi_i

   , output logic                   timer_irq_o
   , output logic                   software_irq_o
   );

  localparam int cnt_width_lp = (timer_prescale_p > 1) ? $clog2(timer_prescale_p) : 1;

  logic [cnt_width_lp-1:0] cnt_r;
  logic [lite_mem_pkg::data_width_c-1:0] mtime_r, mtimecmp_r, rdata;
  logic msip_r, resp_v_r, accept, is_wr, tick;
  logic [lite_addr_pkg::offset_width_c-1:0] offset;
  lite_mem_pkg::mem_msg_s resp_r;

  assign accept = cmd_v_i & cmd_ready_and_o;
  assign is_wr  = (cmd_i.header.opcode == lite_mem_pkg::e_uc_wr);
  assign offset = cmd_i.header.addr.loc.offset;
  assign tick   = (cnt_r == cnt_width_lp'(timer_prescale_p - 1));

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      cnt_r <= '0;
    else if (tick)
      cnt_r <= '0;
    else
      cnt_r <= cnt_r + 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      msip_r     <= 1'b0;
      mtime_r    <= '0;
      mtimecmp_r <= '1;
    end
    else
    begin
      // A write to mtime takes over from the increment
      if (accept & is_wr & (offset == lite_addr_pkg::clint_mtime_c))
        mtime_r <= cmd_i.data;
      else if (tick)
        mtime_r <= mtime_r + 1'b1;

      if (accept & is_wr & (offset == lite_addr_pkg::clint_mtimecmp_c))
        mtimecmp_r <= cmd_i.data;
      if (accept & is_wr & (offset == lite_addr_pkg::clint_msip_c))
        msip_r <= cmd_i.data[0];
    end
  end

  always_comb
  begin
    rdata = '0;
    case (offset)
      lite_addr_pkg::clint_msip_c:     rdata[0] = msip_r;
      lite_addr_pkg::clint_mtimecmp_c: rdata = mtimecmp_r;
      lite_addr_pkg::clint_mtime_c:    rdata = mtime_r;
      default:                         rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r.header <= cmd_i.header;
      resp_r.data   <= is_wr ? '0 : rdata;
    end
  end

  assign cmd_ready_and_o = ~resp_v_r;
  assign resp_o          = resp_r;
  assign resp_v_o        = resp_v_r;
  assign timer_irq_o     = (mtime_r >= mtimecmp_r);
  assign software_irq_o  = msip_r;

endmodule

/* design/uncore_cfg.sv */
`timescale 1ns/1ps

module uncore_cfg
  (input                            clk_i
   , input                          reset_i

   , input lite_mem_pkg::mem_msg_s  cmd_i
   , input                          cmd_v_i
   , output logic                   cmd_ready_and_o

   , output lite_mem_pkg::mem_msg_s resp_o
   , output logic                   resp_v_o
   , input                          resp_yumi_i

   , output logic                   cfg_freeze_o
   );

  logic [lite_mem_pkg::data_width_c-1:0] scratch_r, rdata;
  logic freeze_r, resp_v_r, accept, is_wr;
  logic [lite_addr_pkg::offset_width_c-1:0] offset;
  lite_mem_pkg::mem_msg_s resp_r;

  assign accept = cmd_v_i & cmd_ready_and_o;
  assign is_wr  = (cmd_i.header.opcode == lite_mem_pkg::e_uc_wr);
  assign offset = cmd_i.header.addr.loc.offset;

  // Core comes out of reset frozen
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      freeze_r  <= 1'b1;
      scratch_r <= '0;
    end
    else if (accept & is_wr)
    begin
      if (offset == lite_addr_pkg::cfg_freeze_c)
        freeze_r <= cmd_i.data[0];
      if (offset == lite_addr_pkg::cfg_scratch_c)
        scratch_r <= cmd_i.data;
    end
  end

  always_comb
  begin
    rdata = '0;
    if (offset == lite_addr_pkg::cfg_freeze_c)
      rdata[0] = freeze_r;
    else if (offset == lite_addr_pkg::cfg_scratch_c)
      rdata = scratch_r;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r.header <= cmd_i.header;
      resp_r.data   <= is_wr ? '0 : rdata;
    end
  end

  assign cmd_ready_and_o = ~resp_v_r;
  assign resp_o          = resp_r;
  assign resp_v_o        = resp_v_r;
  assign cfg_freeze_o    = freeze_r;

endmodule

/* design/uncore_loopback.sv */
`timescale 1ns/1ps

module uncore_loopback
  (input                            clk_i
   , input                          reset_i

   , input lite_mem_pkg::mem_msg_s  cmd_i
   , input                          cmd_v_i
   , output logic                   cmd_ready_and_o

   , output lite_mem_pkg::mem_msg_s resp_o
   , output logic                   resp_v_o
   , input                          resp_yumi_i
   );

  lite_mem_pkg::mem_header_s header_r;
  logic resp_v_r, accept;

  assign accept = cmd_v_i & cmd_ready_and_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  // Command data is dropped, only the header comes back
  always_ff @(posedge clk_i)
  begin
    if (accept)
      header_r <= cmd_i.header;
  end

  assign cmd_ready_and_o = ~resp_v_r;
  assign resp_o          = '{header: header_r, data: '0};
  assign resp_v_o        = resp_v_r;

endmodule

/* design/lite_uncore.sv */
`timescale 1ns/1ps

module lite_uncore
  #(parameter int timer_prescale_p = 1)
  (input                                                          clk_i
   , input                                                        reset_i

   , input lite_mem_pkg::mem_msg_s [lite_mem_pkg::num_req_c-1:0]  req_cmd_i
   , input [lite_mem_pkg::num_req_c-1:0]                          req_cmd_v_i
   , output logic [lite_mem_pkg::num_req_c-1:0]                   req_cmd_yumi_o

   , output lite_mem_pkg::mem_msg_s [lite_mem_pkg::num_req_c-1:0] req_resp_o
   , output logic [lite_mem_pkg::num_req_c-1:0]                   req_resp_v_o
   , input [lite_mem_pkg::num_req_c-1:0]                          req_resp_ready_and_i

   // DRAM
   , output lite_mem_pkg::mem_msg_s                               mem_cmd_o
   , output logic                                                 mem_cmd_v_o
   , input                                                        mem_cmd_ready_and_i
   , input lite_mem_pkg::mem_msg_s                                mem_resp_i
   , input                                                        mem_resp_v_i
   , output logic                                                 mem_resp_yumi_o

   // Outgoing I/O
   , output lite_mem_pkg::mem_msg_s                               io_cmd_o
   , output logic                                                 io_cmd_v_o
   , input                                                        io_cmd_ready_and_i
   , input lite_mem_pkg::mem_msg_s                                io_resp_i
   , input                                                        io_resp_v_i
   , output logic                                                 io_resp_yumi_o

   , output logic                                                 timer_irq_o
   , output logic                                                 software_irq_o
   , output logic                                                 cfg_freeze_o
   );

  lite_mem_pkg::mem_msg_s cmd_sel;
  lite_mem_pkg::mem_msg_s clint_resp, cfg_resp, loop_resp;
  logic clint_cmd_v, clint_ready_and, clint_resp_v, clint_resp_yumi;
  logic cfg_cmd_v, cfg_ready_and, cfg_resp_v, cfg_resp_yumi;
  logic loop_cmd_v, loop_ready_and, loop_resp_v, loop_resp_yumi;

  // One selected command fans out to every destination
  assign mem_cmd_o = cmd_sel;
  assign io_cmd_o  = cmd_sel;

  uncore_cmd_router cmd_router
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_cmd_i(req_cmd_i)
     ,.req_cmd_v_i(req_cmd_v_i)
     ,.req_cmd_yumi_o(req_cmd_yumi_o)
     ,.cmd_sel_o(cmd_sel)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.io_cmd_v_o(io_cmd_v_o)
     ,.clint_cmd_v_o(clint_cmd_v)
     ,.cfg_cmd_v_o(cfg_cmd_v)
     ,.loop_cmd_v_o(loop_cmd_v)
     ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
     ,.io_cmd_ready_and_i(io_cmd_ready_and_i)
     ,.clint_ready_and_i(clint_ready_and)
     ,.cfg_ready_and_i(cfg_ready_and)
     ,.loop_ready_and_i(loop_ready_and)
     );

  uncore_resp_router resp_router
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.loop_resp_i(loop_resp)
     ,.loop_resp_v_i(loop_resp_v)
     ,.loop_resp_yumi_o(loop_resp_yumi)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     ,.io_resp_i(io_resp_i)
     ,.io_resp_v_i(io_resp_v_i)
     ,.io_resp_yumi_o(io_resp_yumi_o)
     ,.clint_resp_i(clint_resp)
     ,.clint_resp_v_i(clint_resp_v)
     ,.clint_resp_yumi_o(clint_resp_yumi)
     ,.cfg_resp_i(cfg_resp)
     ,.cfg_resp_v_i(cfg_resp_v)
     ,.cfg_resp_yumi_o(cfg_resp_yumi)
     ,.req_resp_o(req_resp_o)
     ,.req_resp_v_o(req_resp_v_o)
     ,.req_resp_ready_and_i(req_resp_ready_and_i)
     );

  uncore_clint #(.timer_prescale_p(timer_prescale_p)) clint
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_i(cmd_sel)
     ,.cmd_v_i(clint_cmd_v)
     ,.cmd_ready_and_o(clint_ready_and)
     ,.resp_o(clint_resp)
     ,.resp_v_o(clint_resp_v)
     ,.resp_yumi_i(clint_resp_yumi)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  uncore_cfg cfg
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_i(cmd_sel)
     ,.cmd_v_i(cfg_cmd_v)
     ,.cmd_ready_and_o(cfg_ready_and)
     ,.resp_o(cfg_resp)
     ,.resp_v_o(cfg_resp_v)
     ,.resp_yumi_i(cfg_resp_yumi)
     ,.cfg_freeze_o(cfg_freeze_o)
     );

  uncore_loopback loopback
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_i(cmd_sel)
     ,.cmd_v_i(loop_cmd_v)
     ,.cmd_ready_and_o(loop_ready_and)
     ,.resp_o(loop_resp)
     ,.resp_v_o(loop_resp_v)
     ,.resp_yumi_i(loop_resp_yumi)
     );

endmodule

/* tb/lite_uncore_assert.sv */
`timescale 1ns/1ps

module lite_uncore_assert
  (input                           clk_i
   , input                         reset_i
   , input [4:0]                   dest_onehot_i
   , input [2:0]                   req_onehot_i
   , input                         msg_v_i
   , input lite_mem_pkg::mem_msg_s msg_i
   );

  // Destination strobes on the command side, source yumis on the response side
  dest_one: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(dest_onehot_i))
    else $error("more than one destination or source selected");

  req_one: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(req_onehot_i))
    else $error("more than one requester strobe");

  lce_id_range: assert property (@(posedge clk_i) disable iff (reset_i)
    msg_v_i |-> (msg_i.header.lce_id < lite_mem_pkg::num_req_c))
    else $error("routed lce_id out of range");

endmodule

bind uncore_cmd_router lite_uncore_assert cmd_checks
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.dest_onehot_i({loop_cmd_v_o, cfg_cmd_v_o, clint_cmd_v_o, io_cmd_v_o, mem_cmd_v_o})
   ,.req_onehot_i(req_cmd_yumi_o)
   ,.msg_v_i(any_v)
   ,.msg_i(cmd_sel_o)
   );

bind uncore_resp_router lite_uncore_assert resp_checks
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.dest_onehot_i(yumi_lo)
   ,.req_onehot_i(req_resp_v_o)
   ,.msg_v_i(any_v)
   ,.msg_i(winner)
   );

/* tb/tb_lite_uncore.sv */
`timescale 1ns/1ps

module tb_lite_uncore;

  localparam int num_txn_c     = 200;
  localparam int cycle_limit_c = num_txn_c * 64;

  logic clk, reset;
  lite_mem_pkg::mem_msg_s [2:0] req_cmd, req_resp;
  logic [2:0] req_cmd_v, req_cmd_yumi, req_resp_v, req_resp_ready;
  lite_mem_pkg::mem_msg_s mem_cmd, mem_resp, io_cmd, io_resp;
  logic mem_cmd_v, mem_cmd_ready, mem_resp_v, mem_resp_yumi;
  logic io_cmd_v, io_cmd_ready, io_resp_v, io_resp_yumi;
  logic timer_irq, software_irq, cfg_freeze;

  integer seed, errors, checks, cycles, sent;
  logic finished, timed_out;
  // Destinations: 0 mem, 1 io, 2 clint, 3 cfg, 4 loopback
  logic [63:0] ext_mem [logic [31:0]];
  lite_mem_pkg::mem_msg_s exp_resp [3];
  int exp_src [3];
  logic [2:0] pending;
  logic [4:0] busy;
  lite_mem_pkg::mem_msg_s mem_q [$];
  lite_mem_pkg::mem_msg_s io_q [$];
  int mem_wait, io_wait;
  logic freeze_m, msip_m;
  logic [63:0] scratch_m, mtime_m, mtime_next, mtimecmp_m;

  lite_uncore #(.timer_prescale_p(1)) u_lite_uncore
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.req_cmd_i(req_cmd)
     ,.req_cmd_v_i(req_cmd_v)
     ,.req_cmd_yumi_o(req_cmd_yumi)
     ,.req_resp_o(req_resp)
     ,.req_resp_v_o(req_resp_v)
     ,.req_resp_ready_and_i(req_resp_ready)
     ,.mem_cmd_o(mem_cmd)
     ,.mem_cmd_v_o(mem_cmd_v)
     ,.mem_cmd_ready_and_i(mem_cmd_ready)
     ,.mem_resp_i(mem_resp)
     ,.mem_resp_v_i(mem_resp_v)
     ,.mem_resp_yumi_o(mem_resp_yumi)
     ,.io_cmd_o(io_cmd)
     ,.io_cmd_v_o(io_cmd_v)
     ,.io_cmd_ready_and_i(io_cmd_ready)
     ,.io_resp_i(io_resp)
     ,.io_resp_v_i(io_resp_v)
     ,.io_resp_yumi_o(io_resp_yumi)
     ,.timer_irq_o(timer_irq)
     ,.software_irq_o(software_irq)
     ,.cfg_freeze_o(cfg_freeze)
     );

  task automatic check_equal(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int dest_of(input logic [31:0] a);
    logic [3:0] dev;
    dev = a[23:20];
    if (a >= lite_addr_pkg::dram_base_c || dev == lite_addr_pkg::cache_dev_c)
      return 0;
    if (dev == lite_addr_pkg::host_dev_c || dev == lite_addr_pkg::boot_dev_c)
      return 1;
    if (dev == lite_addr_pkg::clint_dev_c)
      return 2;
    if (dev == lite_addr_pkg::cfg_dev_c)
      return 3;
    return 4;
  endfunction

  // Unwritten words read back a pattern of their full address
  function automatic logic [63:0] ext_read(input logic [31:0] a);
    if (ext_mem.exists(a))
      return ext_mem[a];
    return {~a, a ^ 32'h3c5a_96e1};
  endfunction

  function automatic lite_mem_pkg::mem_msg_s port_response(input lite_mem_pkg::mem_msg_s cmd);
    lite_mem_pkg::mem_msg_s resp;
    resp = cmd;
    resp.data = '0;
    if (cmd.header.opcode == lite_mem_pkg::e_uc_wr)
      ext_mem[cmd.header.addr.raw] = cmd.data;
    else
      resp.data = ext_read(cmd.header.addr.raw);
    return resp;
  endfunction

  task automatic make_cmd(input int id, output lite_mem_pkg::mem_msg_s c);
    int pick;
    logic [31:0] r;
    logic [19:0] off;
    logic [3:0] dev;
    pick = $unsigned($random(seed)) % 10;
    r = $random(seed);
    off = {11'd0, r[8:3], 3'd0};
    dev = r[13:10];
    c.data = {$random(seed), $random(seed)};
    c.header.opcode = r[31] ? lite_mem_pkg::e_uc_wr : lite_mem_pkg::e_uc_rd;
    c.header.size = 2'd3;
    c.header.lce_id = id[1:0];
    case (pick)
      0, 1: dev = 4'd0;
      2: dev = lite_addr_pkg::cache_dev_c;
      3: dev = r[9] ? lite_addr_pkg::host_dev_c : lite_addr_pkg::boot_dev_c;
      4, 5:
      begin
        dev = lite_addr_pkg::clint_dev_c;
        case (r[10:9])
          2'd0: off = lite_addr_pkg::clint_msip_c;
          2'd1: off = lite_addr_pkg::clint_mtimecmp_c;
          2'd2: off = lite_addr_pkg::clint_mtime_c;
          default: off = {r[19:3], 3'd0};
        endcase
        // Bias compare writes towards the two interrupt extremes
        if (r[12:11] == 2'd0)
          c.data = '0;
        else if (r[12:11] == 2'd1)
          c.data = '1;
      end
      6, 7:
      begin
        dev = lite_addr_pkg::cfg_dev_c;
        if (r[10:9] == 2'd0)
          off = lite_addr_pkg::cfg_freeze_c;
        else if (r[10:9] == 2'd1)
          off = lite_addr_pkg::cfg_scratch_c;
      end
      default:
      begin
        if (dev >= 4'd1 && dev <= 4'd5)
          dev = 4'd0;
      end
    endcase
    if (pick < 2)
      c.header.addr.raw = {1'b1, 22'd0, r[8:3], 3'd0};
    else
      c.header.addr.raw = {1'b0, r[30:24], dev, off};
  endtask

  task automatic check_commands();
    int hv, d;
    logic rdy, is_wr;
    logic [19:0] off;
    logic [63:0] rd;
    lite_mem_pkg::mem_msg_s c;
    hv = -1;
    for (int i = 0; i < 3; i++)
      if (req_cmd_v[i])
        hv = i;
    if (hv < 0)
    begin
      check_equal("destination valid while idle", {io_cmd_v, mem_cmd_v}, 2'b00);
      check_equal("yumi while idle", req_cmd_yumi, 3'b000);
      return;
    end
    c = req_cmd[hv];
    d = dest_of(c.header.addr.raw);
    off = c.header.addr.raw[19:0];
    is_wr = (c.header.opcode == lite_mem_pkg::e_uc_wr);
    check_equal("io/mem command valid", {io_cmd_v, mem_cmd_v}, {d == 1, d == 0});
    if (d < 2)
      check_equal("forwarded command", (d == 0) ? mem_cmd : io_cmd, c);
    case (d)
      0: rdy = mem_cmd_ready;
      1: rdy = io_cmd_ready;
      default: rdy = ~busy[d];
    endcase
    check_equal("requester yumi", req_cmd_yumi, rdy ? (3'b001 << hv) : 3'b000);
    if (!rdy)
      return;
    rd = 64'd0;
    if (!is_wr && d < 2)
      rd = ext_read(c.header.addr.raw);
    else if (!is_wr && d == 2)
    begin
      if (off == lite_addr_pkg::clint_msip_c)
        rd = {63'd0, msip_m};
      else if (off == lite_addr_pkg::clint_mtimecmp_c)
        rd = mtimecmp_m;
      else if (off == lite_addr_pkg::clint_mtime_c)
        rd = mtime_m;
    end
    else if (!is_wr && d == 3)
    begin
      if (off == lite_addr_pkg::cfg_freeze_c)
        rd = {63'd0, freeze_m};
      else if (off == lite_addr_pkg::cfg_scratch_c)
        rd = scratch_m;
    end
    else if (is_wr && d == 2)
    begin
      if (off == lite_addr_pkg::clint_msip_c)
        msip_m = c.data[0];
      if (off == lite_addr_pkg::clint_mtimecmp_c)
        mtimecmp_m = c.data;
      if (off == lite_addr_pkg::clint_mtime_c)
        mtime_next = c.data;
    end
    else if (is_wr && d == 3)
    begin
      if (off == lite_addr_pkg::cfg_freeze_c)
        freeze_m = c.data[0];
      if (off == lite_addr_pkg::cfg_scratch_c)
        scratch_m = c.data;
    end
    exp_resp[hv].header = c.header;
    exp_resp[hv].data = rd;
    exp_src[hv] = d;
    pending[hv] = 1'b1;
    if (d >= 2)
      busy[d] = 1'b1;
    req_cmd_v[hv] <= 1'b0;
  endtask

  task automatic check_responses();
    logic [1:0] ext_taken;
    ext_taken = '0;
    for (int i = 0; i < 3; i++)
    begin
      if (req_resp_v[i])
      begin
        check_equal("response with a request outstanding", pending[i], 1'b1);
        check_equal("response message", req_resp[i], exp_resp[i]);
        if (req_resp_ready[i])
        begin
          pending[i] = 1'b0;
          if (exp_src[i] < 2)
            ext_taken[exp_src[i]] = 1'b1;
          else
            busy[exp_src[i]] = 1'b0;
        end
      end
    end
    // The external source is released only when its response is delivered
    check_equal("io/mem response yumi", {io_resp_yumi, mem_resp_yumi}, ext_taken);
  endtask

  task automatic serve_mem();
    if (mem_resp_v && mem_resp_yumi)
    begin
      void'(mem_q.pop_front());
      mem_wait = $unsigned($random(seed)) % 6;
    end
    if (mem_cmd_v && mem_cmd_ready)
    begin
      if (mem_q.size() == 0)
        mem_wait = $unsigned($random(seed)) % 6;
      mem_q.push_back(port_response(mem_cmd));
    end
    if (mem_wait > 0)
      mem_wait--;
    mem_resp_v <= (mem_q.size() != 0) && (mem_wait == 0);
    if (mem_q.size() != 0)
      mem_resp <= mem_q[0];
  endtask

  task automatic serve_io();
    if (io_resp_v && io_resp_yumi)
    begin
      void'(io_q.pop_front());
      io_wait = $unsigned($random(seed)) % 6;
    end
    if (io_cmd_v && io_cmd_ready)
    begin
      if (io_q.size() == 0)
        io_wait = $unsigned($random(seed)) % 6;
      io_q.push_back(port_response(io_cmd));
    end
    if (io_wait > 0)
      io_wait--;
    io_resp_v <= (io_q.size() != 0) && (io_wait == 0);
    if (io_q.size() != 0)
      io_resp <= io_q[0];
  endtask

  task automatic reset_models();
    pending = '0;
    busy = '0;
    freeze_m = 1'b1;
    msip_m = 1'b0;
    scratch_m = '0;
    mtime_m = '0;
    mtimecmp_m = '1;
    mem_wait = 0;
    io_wait = 0;
    mem_q.delete();
    io_q.delete();
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Everything samples pre-edge values, then updates the model and drives
  always @(posedge clk)
  begin : step
    logic [31:0] r;
    lite_mem_pkg::mem_msg_s c;
    if (reset)
      reset_models();
    else
    begin
      cycles++;
      check_equal("cfg_freeze_o", cfg_freeze, freeze_m);
      check_equal("software_irq_o", software_irq, msip_m);
      check_equal("timer_irq_o", timer_irq, mtime_m >= mtimecmp_m);
      mtime_next = mtime_m + 64'd1;
      check_commands();
      check_responses();
      serve_mem();
      serve_io();
      mtime_m = mtime_next;
      if (sent == num_txn_c && req_cmd_v == 3'b000 && pending == 3'b000)
        finished = 1'b1;
      if (cycles >= cycle_limit_c)
        timed_out = 1'b1;
      for (int i = 0; i < 3; i++)
      begin
        r = $random(seed);
        if (!pending[i] && !req_cmd_v[i] && sent < num_txn_c && r[0])
        begin
          make_cmd(i, c);
          req_cmd[i] <= c;
          req_cmd_v[i] <= 1'b1;
          sent++;
        end
      end
      r = $random(seed);
      mem_cmd_ready <= (r[1:0] != 2'b00);
      io_cmd_ready <= (r[3:2] != 2'b00);
      req_resp_ready <= r[6:4] | r[9:7];
    end
  end

  initial
  begin
    seed = 32'h5b8c544c;
    errors = 0;
    checks = 0;
    cycles = 0;
    sent = 0;
    finished = 1'b0;
    timed_out = 1'b0;
    reset = 1'b1;
    req_cmd = '0;
    req_cmd_v = '0;
    req_resp_ready = '0;
    mem_cmd_ready = 1'b0;
    mem_resp = '0;
    mem_resp_v = 1'b0;
    io_cmd_ready = 1'b0;
    io_resp = '0;
    io_resp_v = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    wait (finished || timed_out);
    if (timed_out)
      $display("run stopped after %0d cycles with transactions still open", cycles);
    $display("checks %0d errors %0d transactions %0d", checks, errors, sent);
    if (errors == 0 && !timed_out)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* lite_uncore.f */
design/lite_addr_pkg.sv
design/lite_mem_pkg.sv
design/uncore_cmd_router.sv
design/uncore_resp_router.sv
design/uncore_clint.sv
design/uncore_cfg.sv
design/uncore_loopback.sv
design/lite_uncore.sv
tb/lite_uncore_assert.sv
tb/tb_lite_uncore.sv

/* Makefile */
simulate:
	verilator --binary --timing --assert -Wno-fatal -f lite_uncore.f --top-module tb_lite_uncore -o sim_lite_uncore
	./obj_dir/sim_lite_uncore > sim.log 2>&1 || true
	cat sim.log
	! grep -q "tests failed" sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: simulate clean
